/* verilog/searchPkg.sv */
package searchPkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Cell values, tags, keys and result values
    typedef logic [7:0] dataWord;

    // Write index and reported cell index
    typedef logic [7:0] cellIndex;

    // Busy cycle counter, wraps at its width
    typedef logic [23:0] cycleCount;

    //////////////////////////////
    // Search operations
    //////////////////////////////

    // Code 3 is illegal
    typedef enum logic [1:0] {
        OP_MAX   = 2'd0,
        OP_MIN   = 2'd1,
        OP_MATCH = 2'd2
    } searchOp;

    //////////////////////////////
    // Array shape and timing
    //////////////////////////////

    // Power of two only
    localparam int CELL_COUNT = 8;

    // log2 of CELL_COUNT, one registered level each
    localparam int TREE_LEVELS = 3;

    // Edges from the start sample to the done edge
    // cell 1 + tree levels + collector 1
    localparam int LATENCY = 5;

endpackage

/* verilog/memoryCell.sv */
module memoryCell #(
    parameter int position = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               write,
    input  searchPkg::cellIndex index,
    input  searchPkg::dataWord  data,
    input  logic               isMetadata,
    input  logic               start,
    input  searchPkg::searchOp  selector,
    input  searchPkg::dataWord  key,
    output logic               candValid,
    output logic               candHit,
    output searchPkg::searchOp  candOp,
    output searchPkg::dataWord  candValue,
    output searchPkg::cellIndex candIndex
);

    searchPkg::dataWord value;
    searchPkg::dataWord tag;
    logic               written;
    logic               selected;
    logic               queryHit;

    assign selected = write && (index == searchPkg::cellIndex'(position));

    // Tag compare only matters for MATCH
    assign queryHit = written &&
                      (selector != searchPkg::OP_MATCH || tag == key);

    // Fixed for the life of the cell
    assign candIndex = searchPkg::cellIndex'(position);

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            value   <= '0;
            tag     <= '0;
            written <= 1'b0;
        end else if (selected) begin
            if (isMetadata) begin
                tag <= data;
            end else begin
                value   <= data;
                written <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Query candidate
    //////////////////////////////

    // Samples contents from before any write at this same edge
    always_ff @(posedge clk) begin
        if (!reset) begin
            candValid <= 1'b0;
        end else begin
            candValid <= start;
        end
        if (start) begin
            candHit   <= queryHit;
            candOp    <= selector;
            candValue <= value;
        end
    end

    selectorLegal: assert property (
        @(posedge clk) disable iff (!reset)
        start |-> selector inside {searchPkg::OP_MAX, searchPkg::OP_MIN, searchPkg::OP_MATCH}
    );

endmodule

/* verilog/nodeCombinator.sv */
module nodeCombinator (
    input  searchPkg::searchOp  op,
    input  logic               leftHit,
    input  searchPkg::dataWord  leftValue,
    input  searchPkg::cellIndex leftIndex,
    input  logic               rightHit,
    input  searchPkg::dataWord  rightValue,
    input  searchPkg::cellIndex rightIndex,
    output logic               hit,
    output searchPkg::dataWord  value,
    output searchPkg::cellIndex index
);

    logic leftWins;

    // Ties and MATCH go to the left, which holds the lower index
    always_comb begin
        leftWins = 1'b1;
        if (leftHit && rightHit) begin
            case (op)
                searchPkg::OP_MAX: leftWins = (leftValue >= rightValue);
                searchPkg::OP_MIN: leftWins = (leftValue <= rightValue);
                default:           leftWins = 1'b1;
            endcase
        end else begin
            leftWins = leftHit;
        end
    end

    always_comb begin
        hit = leftHit || rightHit;
        if (!hit) begin
            // Empty candidate reads as zero
            value = '0;
            index = '0;
        end else if (leftWins) begin
            value = leftValue;
            index = leftIndex;
        end else begin
            value = rightValue;
            index = rightIndex;
        end
    end

endmodule

/* verilog/reductionTree.sv */
module reductionTree (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            leafValid,
    input  searchPkg::searchOp                               leafOp,
    input  logic [searchPkg::CELL_COUNT-1:0]                 leafHit,
    input  searchPkg::dataWord [searchPkg::CELL_COUNT-1:0]   leafValue,
    input  searchPkg::cellIndex [searchPkg::CELL_COUNT-1:0]  leafIndex,
    output logic                                            outValid,
    output searchPkg::searchOp                               outOp,
    output logic                                            outHit,
    output searchPkg::dataWord                               outValue,
    output searchPkg::cellIndex                              outIndex,
    output logic                                            busy
);

    localparam int LEVELS = searchPkg::TREE_LEVELS;
    localparam int CELLS  = searchPkg::CELL_COUNT;

    // Entry 0 is the leaves, entry n the registers after level n
    logic                stageValid [LEVELS+1];
    searchPkg::searchOp  stageOp [LEVELS+1];
    logic                nodeHit [LEVELS+1][CELLS];
    searchPkg::dataWord  nodeValue [LEVELS+1][CELLS];
    searchPkg::cellIndex nodeIndex [LEVELS+1][CELLS];

    assign stageValid[0] = leafValid;
    assign stageOp[0]    = leafOp;

    for (genvar leaf = 0; leaf < CELLS; leaf++) begin : leafMap
        assign nodeHit[0][leaf]   = leafHit[leaf];
        assign nodeValue[0][leaf] = leafValue[leaf];
        assign nodeIndex[0][leaf] = leafIndex[leaf];
    end

    //////////////////////////////
    // Merge levels
    //////////////////////////////

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : level
        localparam int NODES = CELLS >> (lvl + 1);

        logic               validReg;
        searchPkg::searchOp opReg;

        always_ff @(posedge clk) begin
            if (!reset) begin
                validReg <= 1'b0;
            end else begin
                validReg <= stageValid[lvl];
            end
            opReg <= stageOp[lvl];
        end

        assign stageValid[lvl+1] = validReg;
        assign stageOp[lvl+1]    = opReg;

        for (genvar n = 0; n < NODES; n++) begin : node
            logic                mergedHit;
            searchPkg::dataWord  mergedValue;
            searchPkg::cellIndex mergedIndex;
            logic                hitReg;
            searchPkg::dataWord  valueReg;
            searchPkg::cellIndex indexReg;

            nodeCombinator comb (
                .op(stageOp[lvl]),
                .leftHit(nodeHit[lvl][2*n]),
                .leftValue(nodeValue[lvl][2*n]),
                .leftIndex(nodeIndex[lvl][2*n]),
                .rightHit(nodeHit[lvl][2*n+1]),
                .rightValue(nodeValue[lvl][2*n+1]),
                .rightIndex(nodeIndex[lvl][2*n+1]),
                .hit(mergedHit),
                .value(mergedValue),
                .index(mergedIndex)
            );

            always_ff @(posedge clk) begin
                hitReg   <= mergedHit;
                valueReg <= mergedValue;
                indexReg <= mergedIndex;
            end

            assign nodeHit[lvl+1][n]   = hitReg;
            assign nodeValue[lvl+1][n] = valueReg;
            assign nodeIndex[lvl+1][n] = indexReg;
        end

        stageOpLegal: assert property (
            @(posedge clk) disable iff (!reset)
            stageValid[lvl+1] |->
                stageOp[lvl+1] inside {searchPkg::OP_MAX, searchPkg::OP_MIN, searchPkg::OP_MATCH}
        );
    end

    assign outValid = stageValid[LEVELS];
    assign outOp    = stageOp[LEVELS];
    assign outHit   = nodeHit[LEVELS][0];
    assign outValue = nodeValue[LEVELS][0];
    assign outIndex = nodeIndex[LEVELS][0];

    // Any query sitting in the cells or a stage
    always_comb begin
        busy = 1'b0;
        for (int l = 0; l <= LEVELS; l++) begin
            busy = busy || stageValid[l];
        end
    end

endmodule

/* verilog/resultCollector.sv */
module resultCollector (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inValid,
    input  logic                 inHit,
    input  searchPkg::dataWord   inValue,
    input  searchPkg::cellIndex  inIndex,
    input  logic                 busy,
    output logic                 done,
    output logic                 found,
    output searchPkg::dataWord   resultValue,
    output searchPkg::cellIndex  resultIndex,
    output searchPkg::cycleCount busyCycles
);

    always_ff @(posedge clk) begin
        if (!reset) begin
            done        <= 1'b0;
            found       <= 1'b0;
            resultValue <= '0;
            resultIndex <= '0;
        end else begin
            done <= inValid;
            // Held until the next done
            if (inValid) begin
                found       <= inHit;
                resultValue <= inValue;
                resultIndex <= inIndex;
            end
        end
    end

    //////////////////////////////
    // Busy counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            busyCycles <= '0;
        end else if (busy) begin
            busyCycles <= busyCycles + 1'b1;
        end
    end

    busyStep: assert property (
        @(posedge clk) disable iff (!reset)
        $past(reset) |->
            (busyCycles == $past(busyCycles)) ||
            (busyCycles == searchPkg::cycleCount'($past(busyCycles) + 1'b1))
    );

endmodule

/* verilog/searchArray.sv */
module searchArray (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write,
    input  searchPkg::cellIndex  index,
    input  searchPkg::dataWord   data,
    input  logic                 isMetadata,
    input  logic                 start,
    input  searchPkg::searchOp   selector,
    input  searchPkg::dataWord   key,
    output logic                 done,
    output logic                 found,
    output searchPkg::dataWord   resultValue,
    output searchPkg::cellIndex  resultIndex,
    output searchPkg::cycleCount busyCycles
);

    // Valid and op come from cell 0, the others carry the same bits
    logic                                                leafValid;
    searchPkg::searchOp                                  leafOp;
    logic [searchPkg::CELL_COUNT-1:0]                    cellHit;
    searchPkg::dataWord [searchPkg::CELL_COUNT-1:0]      cellValue;
    searchPkg::cellIndex [searchPkg::CELL_COUNT-1:0]     cellIdx;
    logic                                                treeValid;
    logic                                                treeHit;
    searchPkg::dataWord                                  treeValue;
    searchPkg::cellIndex                                 treeIndex;
    logic                                                treeBusy;

    //////////////////////////////
    // Cells
    //////////////////////////////

    memoryCell #(.position(0)) cell0 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(leafValid), .candHit(cellHit[0]), .candOp(leafOp),
        .candValue(cellValue[0]), .candIndex(cellIdx[0])
    );
    memoryCell #(.position(1)) cell1 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(), .candHit(cellHit[1]), .candOp(),
        .candValue(cellValue[1]), .candIndex(cellIdx[1])
    );
    memoryCell #(.position(2)) cell2 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(), .candHit(cellHit[2]), .candOp(),
        .candValue(cellValue[2]), .candIndex(cellIdx[2])
    );
    memoryCell #(.position(3)) cell3 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(), .candHit(cellHit[3]), .candOp(),
        .candValue(cellValue[3]), .candIndex(cellIdx[3])
    );
    memoryCell #(.position(4)) cell4 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(), .candHit(cellHit[4]), .candOp(),
        .candValue(cellValue[4]), .candIndex(cellIdx[4])
    );
    memoryCell #(.position(5)) cell5 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(), .candHit(cellHit[5]), .candOp(),
        .candValue(cellValue[5]), .candIndex(cellIdx[5])
    );
    memoryCell #(.position(6)) cell6 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(), .candHit(cellHit[6]), .candOp(),
        .candValue(cellValue[6]), .candIndex(cellIdx[6])
    );
    memoryCell #(.position(7)) cell7 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .candValid(), .candHit(cellHit[7]), .candOp(),
        .candValue(cellValue[7]), .candIndex(cellIdx[7])
    );

    //////////////////////////////
    // Reduction and result
    //////////////////////////////

    reductionTree tree0 (
        .clk, .reset,
        .leafValid, .leafOp,
        .leafHit(cellHit), .leafValue(cellValue), .leafIndex(cellIdx),
        .outValid(treeValid), .outOp(), .outHit(treeHit),
        .outValue(treeValue), .outIndex(treeIndex),
        .busy(treeBusy)
    );

    resultCollector collector0 (
        .clk, .reset,
        .inValid(treeValid), .inHit(treeHit), .inValue(treeValue), .inIndex(treeIndex),
        .busy(treeBusy),
        .done, .found, .resultValue, .resultIndex, .busyCycles
    );

endmodule

/* sim/searchArrayTb.sv */
module searchArrayTb;

    localparam int CLOCK_PERIOD = 4;
    localparam int CELLS = searchPkg::CELL_COUNT;

    // Operation budget per phase, for the watchdog
    localparam int EMPTY_OPS     = 18;
    localparam int ISOLATED_RUNS = 40;
    localparam int MISS_RUNS     = 10;
    localparam int BURST_CYCLES  = 200;
    localparam int SAME_OPS      = 2;
    localparam int IGNORED_RUNS  = 12;
    localparam int TOTAL_OPS = EMPTY_OPS + ISOLATED_RUNS * 4 + MISS_RUNS + BURST_CYCLES +
                               SAME_OPS + IGNORED_RUNS * 3;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 100;

    logic                 clk;
    logic                 reset;
    logic                 write;
    searchPkg::cellIndex  index;
    searchPkg::dataWord   data;
    logic                 isMetadata;
    logic                 start;
    searchPkg::searchOp   selector;
    searchPkg::dataWord   key;
    logic                 done;
    logic                 found;
    searchPkg::dataWord   resultValue;
    searchPkg::cellIndex  resultIndex;
    searchPkg::cycleCount busyCycles;

    // Reference model of the cells
    logic [7:0]  modelValue [CELLS];
    logic [7:0]  modelTag [CELLS];
    logic        modelWritten [CELLS];
    logic [23:0] modelBusy;
    logic [3:0]  recentStarts;
    logic [31:0] rngState;
    int          edgeCount;

    // Pending results: due edge, {found, value, index}, name
    int          dueQ [$];
    logic [16:0] expectQ [$];
    string       nameQ [$];

    searchArray dut0 (
        .clk, .reset, .write, .index, .data, .isMetadata, .start, .selector, .key,
        .done, .found, .resultValue, .resultIndex, .busyCycles
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic int randomBelow(input int limit);
        logic [31:0] r;
        r = nextRandom();
        return int'({16'd0, r[30:15]}) % limit;
    endfunction

    // Small values half the time so ties show up
    function automatic logic [7:0] randomData();
        if (randomBelow(2) == 0) begin
            return 8'(randomBelow(16));
        end
        return 8'(randomBelow(256));
    endfunction

    function automatic searchPkg::searchOp randomOp();
        case (randomBelow(3))
            0:       return searchPkg::OP_MAX;
            1:       return searchPkg::OP_MIN;
            default: return searchPkg::OP_MATCH;
        endcase
    endfunction

    function automatic logic [7:0] randomKey();
        if (randomBelow(2) == 0) begin
            return modelTag[randomBelow(CELLS)];
        end
        return randomData();
    endfunction

    function automatic logic tagPresent(input logic [7:0] probe);
        for (int c = 0; c < CELLS; c++) begin
            if (modelWritten[c] && modelTag[c] == probe) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Scan in index order, first best wins
    function automatic logic [16:0] expectResult(input searchPkg::searchOp op,
                                                 input logic [7:0] probe);
        logic       hitAny;
        logic       hit;
        logic [7:0] bestValue;
        logic [7:0] bestIndex;
        hitAny = 1'b0;
        bestValue = 8'd0;
        bestIndex = 8'd0;
        for (int c = 0; c < CELLS; c++) begin
            hit = modelWritten[c] && (op != searchPkg::OP_MATCH || modelTag[c] == probe);
            if (hit && (!hitAny || (op == searchPkg::OP_MAX && modelValue[c] > bestValue) ||
                        (op == searchPkg::OP_MIN && modelValue[c] < bestValue))) begin
                hitAny = 1'b1;
                bestValue = modelValue[c];
                bestIndex = 8'(c);
            end
        end
        return {hitAny, bestValue, bestIndex};
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected 0x%0h actual 0x%0h", testName, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Cycle handling
    //////////////////////////////

    task automatic advanceClock();
        logic [16:0] expected;
        string       name;
        @(posedge clk);
        #1;
        edgeCount++;
        // Busy while a start sits within its four busy edges
        if (recentStarts != 4'd0) begin
            modelBusy = modelBusy + 24'd1;
        end
        recentStarts = {recentStarts[2:0], start};
        checkValue("busy counter", 32'(modelBusy), 32'(busyCycles));
        if (dueQ.size() > 0 && dueQ[0] == edgeCount) begin
            void'(dueQ.pop_front());
            expected = expectQ.pop_front();
            name = nameQ.pop_front();
            checkValue({name, " done"}, 32'd1, 32'(done));
            checkValue({name, " found"}, 32'(expected[16]), 32'(found));
            checkValue({name, " value"}, 32'(expected[15:8]), 32'(resultValue));
            checkValue({name, " index"}, 32'(expected[7:0]), 32'(resultIndex));
        end else begin
            checkValue("done without query", 32'd0, 32'(done));
        end
    endtask

    task automatic driveCycle(input logic doWrite, input logic [7:0] wIndex,
                              input logic [7:0] wData, input logic wMeta,
                              input logic doStart, input searchPkg::searchOp op,
                              input logic [7:0] qKey, input string name);
        write = doWrite;
        index = wIndex;
        data = wData;
        isMetadata = wMeta;
        start = doStart;
        selector = op;
        key = qKey;
        // Query sees contents from before this write
        if (doStart) begin
            // The sample edge is the first of the LATENCY edges
            dueQ.push_back(edgeCount + searchPkg::LATENCY);
            expectQ.push_back(expectResult(op, qKey));
            nameQ.push_back(name);
        end
        if (doWrite && 32'(wIndex) < CELLS) begin
            if (wMeta) begin
                modelTag[wIndex[2:0]] = wData;
            end else begin
                modelValue[wIndex[2:0]] = wData;
                modelWritten[wIndex[2:0]] = 1'b1;
            end
        end
        advanceClock();
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, 8'd0, 8'd0, 1'b0, 1'b0, searchPkg::OP_MAX, 8'd0, "");
    endtask

    task automatic drainQueries();
        while (dueQ.size() > 0) begin
            idleCycle();
        end
    endtask

    task automatic queryAlone(input searchPkg::searchOp op, input logic [7:0] qKey,
                              input string name);
        driveCycle(1'b0, 8'd0, 8'd0, 1'b0, 1'b1, op, qKey, name);
        drainQueries();
    endtask

    task automatic randomWrite(input int indexLimit);
        driveCycle(1'b1, 8'(randomBelow(indexLimit)), randomData(), randomBelow(2) == 0,
                   1'b0, searchPkg::OP_MAX, 8'd0, "");
    endtask

    //////////////////////////////
    // Watchdog
    //////////////////////////////

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired, the search array never delivered all results");
        $display("tests failed");
        $fatal(1);
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [7:0] missKey;
        reset = 1'b0;
        write = 1'b0;
        index = '0;
        data = '0;
        isMetadata = 1'b0;
        start = 1'b0;
        selector = searchPkg::OP_MAX;
        key = '0;
        rngState = 32'h3cd9;
        modelBusy = '0;
        recentStarts = '0;
        edgeCount = 0;
        for (int c = 0; c < CELLS; c++) begin
            modelValue[c] = 8'd0;
            modelTag[c] = 8'd0;
            modelWritten[c] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;

        // Quiet after reset
        repeat (10) begin
            idleCycle();
            checkValue("reset found", 32'd0, 32'(found));
        end

        // Nothing written yet, tags alone do not make a hit
        queryAlone(searchPkg::OP_MAX, 8'd0, "empty MAX");
        queryAlone(searchPkg::OP_MIN, 8'd0, "empty MIN");
        queryAlone(searchPkg::OP_MATCH, 8'd0, "empty MATCH");
        for (int c = 0; c < 4; c++) begin
            driveCycle(1'b1, 8'(c), 8'h5a, 1'b1, 1'b0, searchPkg::OP_MAX, 8'd0, "");
        end
        queryAlone(searchPkg::OP_MATCH, 8'h5a, "tag only MATCH");

        repeat (ISOLATED_RUNS) begin
            repeat (1 + randomBelow(3)) randomWrite(CELLS);
            queryAlone(randomOp(), randomKey(), "isolated query");
        end

        repeat (MISS_RUNS) begin
            missKey = randomData();
            while (tagPresent(missKey)) begin
                missKey = missKey + 8'd1;
            end
            queryAlone(searchPkg::OP_MATCH, missKey, "missed MATCH");
        end

        // Pipelined starts with writes mixed in
        repeat (BURST_CYCLES) begin
            driveCycle(randomBelow(2) == 0, 8'(randomBelow(CELLS)), randomData(),
                       randomBelow(2) == 0, randomBelow(4) != 0, randomOp(), randomKey(),
                       "burst query");
        end
        drainQueries();

        driveCycle(1'b1, 8'd2, 8'hff, 1'b0, 1'b1, searchPkg::OP_MAX, 8'd0, "same edge MAX");
        driveCycle(1'b0, 8'd0, 8'd0, 1'b0, 1'b1, searchPkg::OP_MAX, 8'd0, "after write MAX");
        drainQueries();

        // Out of range writes
        repeat (IGNORED_RUNS) begin
            randomWrite(256 - CELLS);
            driveCycle(1'b1, 8'(CELLS + randomBelow(256 - CELLS)), 8'hff,
                       randomBelow(2) == 0, 1'b0, searchPkg::OP_MAX, 8'd0, "");
            queryAlone(randomOp(), randomKey(), "ignored write query");
        end

        if (dueQ.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Some queries never delivered their done pulse");
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

/* searchArray.f */
verilog/searchPkg.sv
verilog/memoryCell.sv
verilog/nodeCombinator.sv
verilog/reductionTree.sv
verilog/resultCollector.sv
verilog/searchArray.sv
sim/searchArrayTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run; pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module searchArrayTb -f searchArray.f -o searchArraySim &&
./obj_dir/searchArraySim | tee /dev/stderr | grep -q "all tests passed" &&
echo "RESULT: PASS" ||
{ echo "RESULT: FAIL"; exit 1; }
